// ==== Bender.yml ====
package:
  name: core_wb

export_include_dirs:
  - include

sources:
  - source/core_pkg.sv
  - source/core_wb_if.sv
  - source/core_cycle_sequencer.sv
  - source/core_control_writeback.sv
  - source/core_regfile.sv
  - source/core_wb_top.sv
  - target: test
    files:
      - dv/core_wb_tb.sv

// ==== core_wb_top.f ====
+incdir+include
source/core_pkg.sv
source/core_wb_if.sv
source/core_cycle_sequencer.sv
source/core_control_writeback.sv
source/core_regfile.sv
source/core_wb_top.sv
dv/core_wb_tb.sv

// ==== dv/core_wb_tb.sv ====
`timescale 1ns/1ps
`include "core_settings.svh"

module core_wb_tb;
	import core_pkg::*;

	logic     clk;
	logic     arst_n;
	logic     issue;
	reg_num   dec_rd;
	reg_num   dec_ra;
	reg_num   dec_rd_hi;
	logic     dec_writeback;
	logic     dec_update_flags;
	logic     dec_is_mem;
	logic     dec_mem_write;
	logic     dec_base_wb;
	logic     dec_is_mul;
	logic     dec_mul_long;
	logic     exception;
	word      q_alu;
	psr_flags alu_flags;
	logic     mem_ready;
	word      mem_data_rd;
	word      mul_q_lo;
	word      mul_q_hi;
	word      vector;
	reg_num   rd_addr;
	logic     busy;
	word      rd_data;
	psr_flags flags;
	logic     wb_en;
	reg_num   wb_rd;
	word      wb_value;

	word      model_regs [`CORE_NUM_REGS]; // Reference register file
	psr_flags model_flags;
	reg_num   held_rd;
	int       checks;
	int       errors;
	int       test_checks;
	int       test_errors;
	int       tests;

	core_wb_top u_core_wb_top (.*);

	always #50 clk = ~clk;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Scoreboard
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic compare_value(input string name, input word got, input word exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
		end
	endtask

	// Write bus as the register file sees it at this rising edge
	task automatic expect_write(input logic en, input reg_num rd, input word value);
		@(posedge clk);
		compare_value("wb_en", wb_en, en);
		if (en) begin
			compare_value("wb_rd", wb_rd, rd);
			compare_value("wb_value", wb_value, value);
			model_regs[rd] = value;
			held_rd = rd;
		end else begin
			compare_value("wb_rd", wb_rd, held_rd); // Previous destination held
		end
		@(negedge clk);
	endtask

	task automatic verify_reg_file();
		for (int i = 0; i < `CORE_NUM_REGS; i++) begin
			rd_addr = i;
			@(negedge clk);
			compare_value($sformatf("rd_data (r%0d)", i), rd_data, model_regs[i]);
		end
		compare_value("flags", flags, model_flags);
	endtask

	task automatic wait_for_idle();
		int n;
		n = 0;
		while (busy !== 1'b0 && n < 20) begin
			@(negedge clk);
			n++;
		end
		if (busy !== 1'b0) begin
			$display("Timeout: busy still high after %0d cycles", n);
			$display("Simulation FAILED");
			$finish;
		end
	endtask

	task automatic report_test(input string name);
		tests++;
		$display("test %-10s %0d checks, %0d errors", name,
			checks - test_checks, errors - test_errors);
		test_checks = checks;
		test_errors = errors;
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// One instruction of kind 0 ALU, 1 load/store, 2 multiply or 3 exception
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic run_instruction(input int kind, input bit poke_busy);
		int       waits;
		psr_flags new_flags;
		psr_flags old_flags;
		waits            = $urandom_range(0, 4);
		new_flags        = $urandom_range(0, 15);
		old_flags        = model_flags;
		dec_rd           = $urandom_range(0, 15);
		dec_ra           = $urandom_range(0, 15);
		dec_rd_hi        = $urandom_range(0, 15);
		dec_writeback    = $urandom_range(0, 1);
		dec_update_flags = $urandom_range(0, 1);
		dec_mem_write    = $urandom_range(0, 1);
		dec_base_wb      = $urandom_range(0, 1);
		dec_mul_long     = $urandom_range(0, 1);
		dec_is_mem       = (kind == 1) || (kind == 3 && $urandom_range(0, 1));
		dec_is_mul       = (kind == 2);
		exception        = (kind == 3);
		vector           = $urandom;
		issue            = 1'b1;
		expect_write(1'b0, '0, '0); // Edge k
		issue     = 1'b0;
		exception = 1'b0;
		q_alu     = $urandom;
		alu_flags = new_flags;
		mul_q_lo  = $urandom;
		mul_q_hi  = $urandom;
		case (kind)
			0: begin
				expect_write(dec_writeback, dec_rd, q_alu);
				compare_value("flags", flags, old_flags); // Flags one edge later
			end
			1: begin
				for (int i = 0; i <= waits; i++) begin
					mem_ready   = (i == waits);
					mem_data_rd = $urandom;
					if (poke_busy && i == 0) begin
						issue         = 1'b1; // Must be ignored
						dec_is_mem    = 1'b0;
						dec_writeback = 1'b1;
					end else begin
						issue = 1'b0;
					end
					expect_write(mem_ready && !dec_mem_write, dec_rd, mem_data_rd);
				end
				issue     = 1'b0;
				mem_ready = 1'b0;
				if (dec_base_wb)
					expect_write(1'b1, dec_ra, q_alu); // Saved base
			end
			2: begin
				compare_value("busy", busy, 1'b1);
				expect_write(1'b1, dec_rd, mul_q_lo);
				if (dec_mul_long) begin
					compare_value("busy", busy, 1'b1);
					expect_write(1'b1, dec_rd_hi, mul_q_hi);
				end
				compare_value("busy", busy, 1'b0);
			end
			default:
				expect_write(1'b1, `R15, vector);
		endcase
		expect_write(1'b0, '0, '0);
		if (kind != 3 && dec_update_flags)
			model_flags = new_flags;
		wait_for_idle();
		verify_reg_file();
	endtask

	initial begin
		void'($urandom(32'hde2e));
		clk              = 1'b0;
		arst_n           = 1'b0;
		issue            = 1'b0;
		dec_rd           = '0;
		dec_ra           = '0;
		dec_rd_hi        = '0;
		dec_writeback    = 1'b0;
		dec_update_flags = 1'b0;
		dec_is_mem       = 1'b0;
		dec_mem_write    = 1'b0;
		dec_base_wb      = 1'b0;
		dec_is_mul       = 1'b0;
		dec_mul_long     = 1'b0;
		exception        = 1'b0;
		q_alu            = '0;
		alu_flags        = '0;
		mem_ready        = 1'b0;
		mem_data_rd      = '0;
		mul_q_lo         = '0;
		mul_q_hi         = '0;
		vector           = '0;
		rd_addr          = '0;
		model_flags      = '0;
		held_rd          = '0;
		for (int i = 0; i < `CORE_NUM_REGS; i++)
			model_regs[i] = '0;

		repeat (3) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;

		compare_value("busy", busy, 1'b0);
		compare_value("wb_en", wb_en, 1'b0);
		verify_reg_file();
		report_test("reset");

		repeat (40) run_instruction(0, 1'b0);
		report_test("alu");
		repeat (40) run_instruction(1, 1'b0);
		report_test("ldst");
		repeat (30) run_instruction(2, 1'b0);
		report_test("multiply");
		repeat (20) run_instruction(3, 1'b0);
		report_test("exception");
		repeat (20) run_instruction(1, 1'b1);
		report_test("busy_issue");

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

// ==== include/core_settings.svh ====
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// Architectural register numbers
`define R14 4'd14 // Link register
`define R15 4'd15 // Program counter

// Size of the general register file
`define CORE_NUM_REGS 16

// Program counter value out of reset
`define CORE_VECTOR_RESET 32'h0000_0000

// Exception entry loads the program counter from the vector input

`endif

// ==== source/core_control_writeback.sv ====
`timescale 1ns/1ps
`include "core_settings.svh"

module core_control_writeback (
	input  logic                 clk,
	input  logic                 arst_n,
	input  core_pkg::insn_decode dec_q,
	input  core_pkg::ctrl_cycle  cycle,
	input  core_pkg::ctrl_cycle  next_cycle,
	input  logic                 issue,
	input  core_pkg::word        q_alu,
	input  core_pkg::psr_flags   alu_flags,
	input  core_pkg::word        mem_data_rd,
	input  core_pkg::word        mul_q_lo,
	input  core_pkg::word        mul_q_hi,
	input  core_pkg::word        vector,
	input  logic                 mem_ready,
	core_wb_if.ctrl              wb
);
	import core_pkg::*;

	reg_num last_rd;
	reg_num final_rd;
	logic   final_writeback;
	logic   final_update_flags;
	logic   capture_base;
	word    saved_base;

	logic   issue_taken;
	logic   write_now;
	reg_num dest;

	assign issue_taken = (cycle == ISSUE) && issue;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Current cycle picks strobe, destination and value
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		write_now   = 1'b0;
		dest        = dec_q.rd;
		wb.wr_value = q_alu;
		unique case (cycle)
			ISSUE:
				write_now = final_writeback && dec_q.writeback; // ALU result
			TRANSFER: begin
				write_now   = mem_ready && !dec_q.mem_write; // Load data only
				wb.wr_value = mem_data_rd;
			end
			MUL: begin
				write_now   = 1'b1;
				wb.wr_value = mul_q_lo;
			end
			BASE_WRITEBACK: begin
				write_now   = 1'b1;
				dest        = final_rd;
				wb.wr_value = saved_base;
			end
			MUL_HI_WB: begin
				write_now   = 1'b1;
				dest        = final_rd;
				wb.wr_value = mul_q_hi;
			end
			EXCEPTION: begin
				write_now   = 1'b1;
				dest        = final_rd;
				wb.wr_value = vector;
			end
		endcase

		wb.writeback = write_now;
		wb.rd        = write_now ? dest : last_rd; // Hold when idle
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Next cycle picks the registered destination
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			last_rd            <= '0;
			final_rd           <= '0;
			final_writeback    <= 1'b0;
			final_update_flags <= 1'b0;
			capture_base       <= 1'b0;
			wb.update_flags    <= 1'b0;
		end else begin
			last_rd            <= wb.rd;
			final_writeback    <= issue_taken && (next_cycle == ISSUE);
			final_update_flags <= issue_taken && (next_cycle != EXCEPTION);
			capture_base       <= issue_taken && (next_cycle == TRANSFER);
			wb.update_flags    <= final_update_flags && dec_q.update_flags;

			case (next_cycle)
				BASE_WRITEBACK: final_rd <= dec_q.ra;
				MUL_HI_WB:      final_rd <= dec_q.rd_hi;
				EXCEPTION:      final_rd <= `R15;
				default:        final_rd <= final_rd;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		wb.wb_alu_flags <= alu_flags; // Flags land one edge after rd
		if (capture_base)
			saved_base <= q_alu; // Address from the ALU
	end

	a_exc_pc: assert property (
		@(posedge clk) disable iff (!arst_n)
		(issue_taken && next_cycle == EXCEPTION) |=> (wb.writeback && wb.rd == `R15)
	) else $error("exception entry did not write R15");

endmodule

// ==== source/core_cycle_sequencer.sv ====
`timescale 1ns/1ps
`include "core_settings.svh"

module core_cycle_sequencer (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 issue,
	input  core_pkg::insn_decode dec,
	input  logic                 exception,
	input  logic                 mem_ready,
	output core_pkg::ctrl_cycle  cycle,
	output core_pkg::ctrl_cycle  next_cycle,
	output core_pkg::insn_decode dec_q,
	output logic                 busy
);
	import core_pkg::*;

	logic issue_taken;

	assign issue_taken = (cycle == ISSUE) && issue;
	assign busy = (cycle != ISSUE);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Next control cycle
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		next_cycle = cycle;
		unique case (cycle)
			ISSUE: begin
				if (issue) begin
					if (exception)
						next_cycle = EXCEPTION; // Instruction is not executed
					else if (dec.is_mem)
						next_cycle = TRANSFER;
					else if (dec.is_mul)
						next_cycle = MUL;
					else
						next_cycle = ISSUE; // Plain ALU op
				end
			end

			TRANSFER: begin
				if (mem_ready)
					next_cycle = dec_q.base_wb ? BASE_WRITEBACK : ISSUE;
			end

			MUL:
				next_cycle = dec_q.mul_long ? MUL_HI_WB : ISSUE;

			BASE_WRITEBACK, MUL_HI_WB, EXCEPTION:
				next_cycle = ISSUE;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cycle <= ISSUE;
		end else begin
			cycle <= next_cycle;
		end
	end

	// Decode stays stable for all later cycles of the instruction
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			dec_q <= '0;
		end else if (issue_taken) begin
			dec_q <= dec;
		end
	end

	// Memory owns the exit from TRANSFER
	a_transfer_hold: assert property (
		@(posedge clk) disable iff (!arst_n)
		(cycle == TRANSFER && !mem_ready) |=> (cycle == TRANSFER)
	) else $error("sequencer left TRANSFER without mem_ready");

endmodule

// ==== source/core_pkg.sv ====
package core_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Basic datapath types
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef logic [31:0] word;
	typedef logic [3:0]  reg_num;

	typedef struct packed {
		logic n;
		logic z;
		logic c;
		logic v;
	} psr_flags;

	// One entry per control cycle of an instruction
	typedef enum logic [2:0] {
		ISSUE,
		TRANSFER,       // Memory access
		BASE_WRITEBACK,
		MUL,            // Low half or short multiply
		MUL_HI_WB,      // High half of long multiply
		EXCEPTION
	} ctrl_cycle;

	typedef struct packed {
		reg_num rd;
		reg_num ra;           // Base register
		reg_num rd_hi;
		logic   writeback;
		logic   update_flags;
		logic   is_mem;
		logic   mem_write;
		logic   base_wb;
		logic   is_mul;
		logic   mul_long;
	} insn_decode;

endpackage

// ==== source/core_regfile.sv ====
`timescale 1ns/1ps
`include "core_settings.svh"

module core_regfile (
	input  logic               clk,
	input  logic               arst_n,
	input  core_pkg::reg_num   rd_addr,
	core_wb_if.rf              wb,
	output core_pkg::word      rd_data,
	output core_pkg::psr_flags flags
);
	import core_pkg::*;

	word regs [`CORE_NUM_REGS];

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// General registers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < `CORE_NUM_REGS; i++) begin
				regs[i] <= '0;
			end
			regs[`R15] <= `CORE_VECTOR_RESET; // PC starts at reset vector
		end else if (wb.writeback) begin
			regs[wb.rd] <= wb.wr_value;
		end
	end

	// Asynchronous read port
	assign rd_data = regs[rd_addr];

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Condition flags
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			flags <= '0;
		end else if (wb.update_flags) begin
			flags <= wb.wb_alu_flags; // NZCV only
		end
	end

endmodule

// ==== source/core_wb_if.sv ====
`timescale 1ns/1ps

interface core_wb_if;
	import core_pkg::*;

	reg_num   rd;
	logic     writeback;
	word      wr_value;
	logic     update_flags;
	psr_flags wb_alu_flags; // Registered copy of the ALU flags

	modport ctrl (
		output rd,
		output writeback,
		output wr_value,
		output update_flags,
		output wb_alu_flags
	);

	modport rf (
		input rd,
		input writeback,
		input wr_value,
		input update_flags,
		input wb_alu_flags
	);
endinterface

// ==== source/core_wb_top.sv ====
`timescale 1ns/1ps

module core_wb_top (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               issue,
	input  core_pkg::reg_num   dec_rd,
	input  core_pkg::reg_num   dec_ra,
	input  core_pkg::reg_num   dec_rd_hi,
	input  logic               dec_writeback,
	input  logic               dec_update_flags,
	input  logic               dec_is_mem,
	input  logic               dec_mem_write,
	input  logic               dec_base_wb,
	input  logic               dec_is_mul,
	input  logic               dec_mul_long,
	input  logic               exception,
	input  core_pkg::word      q_alu,
	input  core_pkg::psr_flags alu_flags,
	input  logic               mem_ready,
	input  core_pkg::word      mem_data_rd,
	input  core_pkg::word      mul_q_lo,
	input  core_pkg::word      mul_q_hi,
	input  core_pkg::word      vector,
	input  core_pkg::reg_num   rd_addr,
	output logic               busy,
	output core_pkg::word      rd_data,
	output core_pkg::psr_flags flags,
	output logic               wb_en,
	output core_pkg::reg_num   wb_rd,
	output core_pkg::word      wb_value
);
	import core_pkg::*;

	insn_decode dec;
	insn_decode dec_q;
	ctrl_cycle  cycle;
	ctrl_cycle  next_cycle;

	core_wb_if wb ();

	assign dec = '{
		rd:           dec_rd,
		ra:           dec_ra,
		rd_hi:        dec_rd_hi,
		writeback:    dec_writeback,
		update_flags: dec_update_flags,
		is_mem:       dec_is_mem,
		mem_write:    dec_mem_write,
		base_wb:      dec_base_wb,
		is_mul:       dec_is_mul,
		mul_long:     dec_mul_long
	};

	core_cycle_sequencer u_sequencer (
		.clk        (clk),
		.arst_n     (arst_n),
		.issue      (issue),
		.dec        (dec),
		.exception  (exception),
		.mem_ready  (mem_ready),
		.cycle      (cycle),
		.next_cycle (next_cycle),
		.dec_q      (dec_q),
		.busy       (busy)
	);

	core_control_writeback u_control_writeback (
		.clk         (clk),
		.arst_n      (arst_n),
		.dec_q       (dec_q),
		.cycle       (cycle),
		.next_cycle  (next_cycle),
		.issue       (issue),
		.q_alu       (q_alu),
		.alu_flags   (alu_flags),
		.mem_data_rd (mem_data_rd),
		.mul_q_lo    (mul_q_lo),
		.mul_q_hi    (mul_q_hi),
		.vector      (vector),
		.mem_ready   (mem_ready),
		.wb          (wb)
	);

	core_regfile u_regfile (
		.clk     (clk),
		.arst_n  (arst_n),
		.rd_addr (rd_addr),
		.wb      (wb),
		.rd_data (rd_data),
		.flags   (flags)
	);

	// Write bus visible at the top for checking
	assign wb_en    = wb.writeback;
	assign wb_rd    = wb.rd;
	assign wb_value = wb.wr_value;

endmodule
